// File: bench/daqStim.txt
// kind 0 command: word | kind F: end of records
// kind 1 trigger: pins {ext,out2,out1,out0} active low, cycles held, hold expected, holdCount after, retrigger cycle
1 0 2 0 0 0       // hold disabled after reset
0 4001 0 0 0 0    // hold enable
1 E 2 1 1 0       // any, one pin
0 1001 0 0 0 0    // all
1 E 2 0 1 0
1 C 2 0 1 0
1 8 2 1 2 0
0 1002 0 0 0 0    // majority
1 A 2 1 3 0
1 E 2 0 3 0
0 1003 0 0 0 0    // external only
1 8 2 0 3 0
1 7 2 1 4 0
0 2005 0 0 0 0    // delay 5
0 3003 0 0 0 0    // time 3
1 7 2 1 5 0
0 2010 0 0 0 0    // delay 16
0 3006 0 0 0 0    // time 6
1 7 3 1 6 0
0 3000 0 0 0 0    // time 0, counted with no pulse
1 7 2 0 7 0
0 2008 0 0 0 0    // delay 8
0 3004 0 0 0 0    // time 4
1 7 2 1 8 6       // retrigger while pending
1 7 2 1 9 A       // retrigger while active
1 7 2 1 A 0       // accepted again once idle
0 0002 0 0 0 0    // unknown opcodes
0 B000 0 0 0 0
0 7003 0 0 0 0
1 8 2 0 A 0
1 7 2 1 B 0
0 4000 0 0 0 0    // hold disable
1 7 2 0 B 0
F 0 0 0 0 0

// File: src.f
design/daqPkg.sv
design/cmdDecoder.sv
design/trigCoincid.sv
design/holdGen.sv
design/daqTop.sv
bench/daqTop_chk.sv
bench/daqTb.sv

// File: bench/daqTb.sv
`timescale 1ns/1ps

module daqTb
    import daqPkg::*;
();

    localparam int clkPeriod = 40;
    localparam int recFields = 6;                   // Kind plus five operands
    localparam int maxRec = 64;
    localparam int riseMargin = 6;                  // Slack past the expected rise
    localparam int fallMargin = 4;                  // Slack past the expected width

    logic                Clk;
    logic                arstN;
    logic [cmdWidth-1:0] cmdWord;
    logic                cmdValid;
    logic [2:0]          outTrigB;
    logic                extTrigB;
    logic                hold;
    holdCount_t          holdCount;

    logic [15:0] stim [0:recFields*maxRec-1];       // Raw records from the stim file
    daqConfig_t  cfgModel;                          // Expected DUT configuration
    integer      seed = 58748;
    int          errCnt;
    int          checkCnt;
    int          testCnt;
    logic [3:0]  evPins;                            // {ext, out2, out1, out0}, active low
    int          evHoldCyc;
    int          evRetrig;
    int          evCyc;                             // Falling edges since the pins went low

    daqTop uut (
        .Clk       (Clk),
        .arstN     (arstN),
        .cmdWord   (cmdWord),
        .cmdValid  (cmdValid),
        .outTrigB  (outTrigB),
        .extTrigB  (extTrigB),
        .hold      (hold),
        .holdCount (holdCount)
    );

    bind daqTop daqTop_chk chk (
        .Clk       (Clk),
        .arstN     (arstN),
        .hold      (hold),
        .holdCount (holdCount),
        .holdEn    (cfg.holdEn)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic checkCount(input string sigName, input holdCount_t got,
                              input holdCount_t exp);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("FAIL at %0t: %s = %0d, expected %0d", $time, sigName, got, exp);
        end
    endtask

    task automatic checkHoldWidth(input logic [holdTimeWidth-1:0] got,
                                  input logic [holdTimeWidth-1:0] exp);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("FAIL at %0t: hold width = %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic checkLatency(input int got, input int exp);
        checkCnt++;
        if (got != exp) begin
            errCnt++;
            $display("FAIL at %0t: hold latency = %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic checkHoldLevel(input string sigName, input logic got, input logic exp);
        checkCnt++;
        if (got !== exp) begin
            errCnt++;
            $display("FAIL at %0t: %s = %b, expected %b", $time, sigName, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model and drivers
    //////////////////////////////////////////////////////////////////////

    // Coincidence rule on active-high pins, bit 3 is external
    function automatic logic coincFires(input coincMode_t mode, input logic [3:0] act);
        case (mode)
            coincAny:      return act[0] || act[1] || act[2];
            coincAll:      return act[0] && act[1] && act[2];
            coincMajority: return (int'(act[0]) + int'(act[1]) + int'(act[2])) >= 2;
            default:       return act[3];
        endcase
    endfunction

    task automatic sendCommand(input logic [cmdWidth-1:0] word);
        @(negedge Clk);
        cmdWord  = word;
        cmdValid = 1'b1;                            // One-cycle strobe
        @(negedge Clk);
        cmdValid = 1'b0;
        cmdWord  = '0;
        case (word[cmdWidth-1 -: opWidth])
            4'd1:    cfgModel.coincMode = coincMode_t'(word[1:0]);
            4'd2:    cfgModel.holdDelay = word[7:0];
            4'd3:    cfgModel.holdTime  = word[11:0];
            4'd4:    cfgModel.holdEn    = word[0];
            default: ;                              // Unknown opcode, model unchanged
        endcase
    endtask

    // One falling edge, pins follow the event schedule
    task automatic advanceCycle();
        @(negedge Clk);
        evCyc++;
        if (evCyc == evHoldCyc || (evRetrig != 0 && evCyc == evRetrig + evHoldCyc)) begin
            {extTrigB, outTrigB} = 4'hF;            // Back to idle high
        end else if (evRetrig != 0 && evCyc == evRetrig) begin
            {extTrigB, outTrigB} = evPins;          // Second trigger while busy
        end
    endtask

    task automatic runTrigger(input logic [3:0] pins, input int holdCyc, input logic expHold,
                              input holdCount_t expCount, input int retrig);
        int   expLat;
        int   riseLimit;
        int   endCyc;
        int   startCyc;
        int   errBefore;
        logic modelHold;
        logic extra;
        testCnt++;
        errBefore = errCnt;
        modelHold = cfgModel.holdEn && coincFires(cfgModel.coincMode, ~pins) &&
                    (cfgModel.holdTime != '0);
        expLat    = 3 + int'(cfgModel.holdDelay) + 1; // Sync and edge, then delay+1
        riseLimit = expLat + riseMargin;
        endCyc    = retrig + holdCyc + expLat + 3;
        if (modelHold !== expHold) begin
            errCnt++;
            $display("Stimulus for test %0d expects hold %0d but the model gives %0d",
                     testCnt, expHold, modelHold);
        end
        evPins    = pins;
        evHoldCyc = holdCyc;
        evRetrig  = retrig;
        evCyc     = 0;
        @(negedge Clk);
        {extTrigB, outTrigB} = pins;
        while (!hold && evCyc < riseLimit) advanceCycle();
        if (!modelHold) begin
            checkHoldLevel("hold", hold, 1'b0);
        end else if (!hold) begin
            errCnt++;
            $display("Timeout: hold did not rise within %0d cycles in test %0d",
                     riseLimit, testCnt);
        end else begin
            checkLatency(evCyc - 1, expLat);        // Count from the first sampling edge
            startCyc = evCyc;
            while (hold && evCyc - startCyc < int'(cfgModel.holdTime) + fallMargin) begin
                advanceCycle();
            end
            if (hold) begin
                errCnt++;
                $display("Timeout: hold stayed high too long in test %0d", testCnt);
            end else begin
                checkHoldWidth(holdTimeWidth'(evCyc - startCyc), cfgModel.holdTime);
            end
        end
        // Quiet tail, a dropped retrigger must not show up late
        extra = 1'b0;
        while (evCyc < endCyc) begin
            advanceCycle();
            extra |= hold;
        end
        checkHoldLevel("hold after the pulse", extra, 1'b0);
        {extTrigB, outTrigB} = 4'hF;
        checkCount("holdCount", holdCount, expCount);
        $display("Test %0d: pins %b mode %s delay %0d time %0d count %0d %s", testCnt, pins,
                 cfgModel.coincMode.name(), cfgModel.holdDelay, cfgModel.holdTime,
                 holdCount, (errCnt == errBefore) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int   rec;
        int   base;
        int   filler;
        int   errTotal;
        logic done;
        cmdWord  = '0;
        cmdValid = 1'b0;
        outTrigB = 3'b111;
        extTrigB = 1'b1;
        arstN    = 1'b0;
        errCnt   = 0;
        checkCnt = 0;
        testCnt  = 0;
        evCyc    = 0;
        cfgModel = '{coincMode: coincAny, holdDelay: 8'd0, holdTime: 12'd1, holdEn: 1'b0};
        $readmemh("bench/daqStim.txt", stim);
        repeat (4) @(posedge Clk);
        @(negedge Clk);
        arstN = 1'b1;
        testCnt++;
        checkHoldLevel("hold", hold, 1'b0);
        checkCount("holdCount", holdCount, '0);
        $display("Test %0d: reset state %s", testCnt, (errCnt == 0) ? "ok" : "FAILED");
        done = 1'b0;
        for (rec = 0; rec < maxRec && !done; rec++) begin
            base   = rec * recFields;
            filler = {$random(seed)} % 4;           // Idle gap between records
            repeat (filler) @(negedge Clk);
            case (stim[base])
                16'h0: sendCommand(stim[base+1]);
                16'h1: runTrigger(stim[base+1][3:0], int'(stim[base+2]), stim[base+3][0],
                                  holdCount_t'(stim[base+4]), int'(stim[base+5]));
                16'hF: done = 1'b1;
                default: begin
                    errCnt++;
                    $display("Stimulus record %0d has no valid kind", rec);
                    done = 1'b1;
                end
            endcase
        end
        errTotal = errCnt + uut.chk.failCount;
        $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 testCnt, checkCnt, errCnt, uut.chk.failCount);
        if (errTotal == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: bench/daqTop_chk.sv
`timescale 1ns/1ps

module daqTop_chk
    import daqPkg::*;
(
    input logic       Clk,
    input logic       arstN,
    input logic       hold,
    input holdCount_t holdCount,
    input logic       holdEn
);

    int failCount = 0;                              // Read by the testbench at the end

    //////////////////////////////////////////////////////////////////////
    // Hold pin and counter properties
    //////////////////////////////////////////////////////////////////////

    // Reset pulls the hold pin down right away
    holdLowInReset: assert property (@(negedge Clk) !arstN |-> !hold)
        else begin failCount++; $error("hold high during reset"); end

    holdNeedsEnable: assert property (@(posedge Clk) disable iff (!arstN)
        $rose(hold) |-> holdEn)
        else begin failCount++; $error("hold rose with holdEn low"); end

    // Counter only ever steps up by one
    countStepsByOne: assert property (@(posedge Clk) disable iff (!arstN)
        (holdCount != $past(holdCount)) |-> (holdCount == holdCount_t'($past(holdCount) + 1)))
        else begin failCount++; $error("holdCount jumped by more than one"); end

endmodule

// File: design/daqTop.sv
`timescale 1ns/1ps

module daqTop
    import daqPkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic [cmdWidth-1:0] cmdWord,    // Host control word
    input  logic                cmdValid,   // Single-cycle strobe
    input  logic [2:0]          outTrigB,   // ASIC trigger pins
    input  logic                extTrigB,   // External trigger pin
    output logic                hold,
    output holdCount_t          holdCount
);

    daqConfig_t cfg;                // Decoded run configuration
    logic       trigPulse;

    //////////////////////////////////////////////////////////////////////
    // Command path, config and trigger paths
    //////////////////////////////////////////////////////////////////////

    cmdDecoder cmdDecoder (
        .Clk      (Clk),
        .arstN    (arstN),
        .cmdWord  (cmdWord),
        .cmdValid (cmdValid),
        .cfg      (cfg)
    );

    trigCoincid trigCoincid (
        .Clk       (Clk),
        .arstN     (arstN),
        .outTrigB  (outTrigB),
        .extTrigB  (extTrigB),
        .coincMode (cfg.coincMode),  // Only the rule is needed here
        .trigPulse (trigPulse)
    );

    holdGen holdGen (
        .Clk       (Clk),
        .arstN     (arstN),
        .trigPulse (trigPulse),
        .cfg       (cfg),
        .hold      (hold),
        .holdCount (holdCount)
    );

endmodule

// File: design/holdGen.sv
`timescale 1ns/1ps

module holdGen
    import daqPkg::*;
(
    input  logic       Clk,
    input  logic       arstN,
    input  logic       trigPulse,   // From the coincidence block
    input  daqConfig_t cfg,
    output logic       hold,        // To the ASIC hold pin
    output holdCount_t holdCount    // Accepted triggers
);

    holdState_t               state;
    logic [holdTimeWidth-1:0] cnt;      // Shared delay and length counter
    logic [holdTimeWidth-1:0] timeLat;  // Hold length taken at accept
    logic                     accept;

    // Only an idle and enabled generator takes a trigger
    assign accept = trigPulse && cfg.holdEn && (state == holdIdle);

    //////////////////////////////////////////////////////////////////////
    // Hold length latch
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (accept) begin
            timeLat <= cfg.holdTime;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM and counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state     <= holdIdle;
            cnt       <= '0;
            hold      <= 1'b0;
            holdCount <= '0;
        end else begin
            case (state)
                holdIdle: begin
                    if (accept) begin
                        holdCount <= holdCount + 1'b1;  // Counted even with zero length
                        cnt       <= holdTimeWidth'(cfg.holdDelay);
                        if (cfg.holdTime != '0) begin
                            state <= holdWait;
                        end
                    end
                end
                holdWait: begin
                    // Delay runs out, hold goes up delay+1 cycles after accept
                    if (cnt == '0) begin
                        state <= holdActive;
                        hold  <= 1'b1;
                        cnt   <= timeLat - 1'b1;        // Nonzero by construction
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                holdActive: begin
                    if (cnt == '0) begin
                        state <= holdIdle;
                        hold  <= 1'b0;                  // High for exactly timeLat cycles
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= holdIdle;
                    hold  <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: design/trigCoincid.sv
`timescale 1ns/1ps

module trigCoincid
    import daqPkg::*;
(
    input  logic       Clk,
    input  logic       arstN,
    input  logic [2:0] outTrigB,    // ASIC triggers, active low
    input  logic       extTrigB,    // External trigger, active low
    input  coincMode_t coincMode,
    output logic       trigPulse    // One cycle per new coincidence
);

    //////////////////////////////////////////////////////////////////////
    // Pin synchronizer
    //////////////////////////////////////////////////////////////////////

    logic [3:0] trigMeta;           // First stage, bit 3 is external
    logic [3:0] trigSync;           // Second stage, safe to use

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            trigMeta <= '0;
            trigSync <= '0;
        end else begin
            trigMeta <= ~{extTrigB, outTrigB};      // Flip to active high here
            trigSync <= trigMeta;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Coincidence rules
    //////////////////////////////////////////////////////////////////////

    logic condSel;
    logic condReg;                  // Selected condition one cycle late

    always_comb begin
        case (coincMode)
            coincAny:      condSel = |trigSync[2:0];
            coincAll:      condSel = &trigSync[2:0];
            // Two of three, any pair will do
            coincMajority: condSel = (trigSync[0] & trigSync[1]) |
                                     (trigSync[0] & trigSync[2]) |
                                     (trigSync[1] & trigSync[2]);
            coincExt:      condSel = trigSync[3];
            default:       condSel = 1'b0;
        endcase
    end

    // Rising edge detect, a condition held true fires only once
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            condReg   <= 1'b0;
            trigPulse <= 1'b0;
        end else begin
            condReg   <= condSel;
            trigPulse <= condSel & ~condReg;        // Registered pulse
        end
    end

endmodule

// File: design/cmdDecoder.sv
`timescale 1ns/1ps

module cmdDecoder
    import daqPkg::*;
(
    input  logic                Clk,
    input  logic                arstN,
    input  logic [cmdWidth-1:0] cmdWord,    // Opcode and operand
    input  logic                cmdValid,   // One word per high cycle
    output daqConfig_t          cfg         // Registered run configuration
);

    //////////////////////////////////////////////////////////////////////
    // Field split
    //////////////////////////////////////////////////////////////////////

    cmdOp_t                  cmdOp;
    logic [operandWidth-1:0] operand;

    // Unlisted opcodes keep their raw value and fall to the default arm
    assign cmdOp   = cmdOp_t'(cmdWord[cmdWidth-1 -: opWidth]);
    assign operand = cmdWord[operandWidth-1:0];

    //////////////////////////////////////////////////////////////////////
    // Configuration register
    //////////////////////////////////////////////////////////////////////

    // Each strobed word touches at most one field of the record.
    // The new value shows on cfg right after the sampling edge.
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            cfg <= cfgReset;                        // Any rule, delay 0, time 1, off
        end else if (cmdValid) begin
            case (cmdOp)
                opSetCoincid: begin
                    // Only the two low bits carry the rule
                    cfg.coincMode <= coincMode_t'(operand[1:0]);
                end
                opSetHoldDelay: begin
                    cfg.holdDelay <= operand[holdDelayWidth-1:0]; // Upper bits ignored
                end
                opSetHoldTime: begin
                    cfg.holdTime <= operand[holdTimeWidth-1:0];   // Full operand
                end
                opHoldEnable: begin
                    cfg.holdEn <= operand[0];
                end
                default: begin
                    cfg <= cfg;                     // Unknown opcode, no change
                end
            endcase
        end
    end

endmodule

// File: design/daqPkg.sv
package daqPkg;

    ////////////////////////////////////////////////////////////////////
    // Command word layout
    ////////////////////////////////////////////////////////////////////

    localparam int cmdWidth = 16;                   // Host control word
    localparam int opWidth = 4;                     // Opcode in the top nibble
    localparam int operandWidth = cmdWidth - opWidth; // Remaining 12 bits

    // Opcodes, anything else is dropped by the decoder
    typedef enum logic [opWidth-1:0] {
        opSetCoincid   = 4'd1,                      // Operand[1:0] -> coincidence rule
        opSetHoldDelay = 4'd2,                      // Operand[7:0] -> hold delay
        opSetHoldTime  = 4'd3,                      // Operand[11:0] -> hold length
        opHoldEnable   = 4'd4                       // Operand[0] -> hold enable
    } cmdOp_t;

    ////////////////////////////////////////////////////////////////////
    // Trigger and hold settings
    ////////////////////////////////////////////////////////////////////

    // Coincidence rule applied to the synchronized trigger pins
    typedef enum logic [1:0] {
        coincAny      = 2'd0,                       // OR of the three ASIC triggers
        coincAll      = 2'd1,                       // AND of the three
        coincMajority = 2'd2,                       // Two out of three
        coincExt      = 2'd3                        // External trigger alone
    } coincMode_t;

    localparam int holdDelayWidth = 8;              // Delay in Clk cycles
    localparam int holdTimeWidth = 12;              // Hold length in Clk cycles
    localparam int countWidth = 16;                 // Issued hold counter

    typedef logic [countWidth-1:0] holdCount_t;

    // Hold generator FSM
    typedef enum logic [1:0] {
        holdIdle,                                   // Waiting for a trigger
        holdWait,                                   // Counting the delay
        holdActive                                  // Hold pin driven high
    } holdState_t;

    // Run configuration as programmed by the host, 23 bits
    typedef struct packed {
        coincMode_t                coincMode;
        logic [holdDelayWidth-1:0] holdDelay;
        logic [holdTimeWidth-1:0]  holdTime;
        logic                      holdEn;
    } daqConfig_t;

    // Power-up values, hold disabled until the host turns it on
    localparam daqConfig_t cfgReset = '{
        coincMode: coincAny,
        holdDelay: '0,
        holdTime:  12'd1,
        holdEn:    1'b0
    };

endpackage
